//--- rtl/mult_ft_pkg.sv
// operator codes, data and counter widths, CSR map and shared types of the multiplier
`default_nettype none

package mult_ft_pkg;

	//////////////////////////////
	// datapath
	//////////////////////////////

	// operand and result width
	localparam int unsigned DATA_W = 32;

	// lanes coming from the issuing pipelines
	localparam int unsigned N_LANES = 4;

	// multiplier replicas behind the voter
	localparam int unsigned N_REP = 3;

	typedef logic [DATA_W-1:0] data_t;

	// MUL and MAC keep the low word, MULH the high word of the signed product
	typedef enum logic [1:0] {
		OP_MUL  = 2'd0,
		OP_MAC  = 2'd1,
		OP_MULH = 2'd2
	} mult_op_e;

	//////////////////////////////
	// CSR map
	//////////////////////////////

	localparam int unsigned CSR_ADDR_W = 12;

	// custom machine-mode read/write range
	// replica k counter sits at base + k
	localparam logic [CSR_ADDR_W-1:0] CSR_CNT_BASE = 12'h7C0;

	// permanent-fault flags in bits 2..0, rest reads zero
	localparam logic [CSR_ADDR_W-1:0] CSR_FAULT_ADDR = CSR_CNT_BASE + 12'd3;

	//////////////////////////////
	// error counters
	//////////////////////////////

	localparam int unsigned CNT_W = 16;

	typedef logic [CNT_W-1:0] cnt_t;

endpackage

`default_nettype wire

//--- rtl/mult_lane_if.sv
// interface carrying one replica's multiply request
`default_nettype none

interface mult_lane_if;

	// operation valid for this replica
	logic enable;

	mult_ft_pkg::mult_op_e op;

	// multiplicand, multiplier and accumulate operand
	mult_ft_pkg::data_t op_a;
	mult_ft_pkg::data_t op_b;
	mult_ft_pkg::data_t op_c;

	// driven by the lane steering stage
	modport source (
		output enable,
		output op,
		output op_a,
		output op_b,
		output op_c
	);

	// read by a multiplier replica
	modport sink (
		input enable,
		input op,
		input op_a,
		input op_b,
		input op_c
	);

endinterface

`default_nettype wire

//--- rtl/lane_steer.sv
// lane steering mux that picks three of four pipeline lanes for the replicas
`default_nettype none

module lane_steer (
	input wire logic [mult_ft_pkg::N_LANES-1:0] enable_i,
	input wire mult_ft_pkg::mult_op_e [mult_ft_pkg::N_LANES-1:0] op_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_a_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_b_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_c_i,

	// per replica, take the spare lane instead of its own
	input wire logic [mult_ft_pkg::N_REP-1:0] sel_lane3_i,

	mult_lane_if.source lane_o [mult_ft_pkg::N_REP]
);

	// the last lane is the spare that can stand in for any replica
	localparam int unsigned SPARE = mult_ft_pkg::N_LANES - 1;

	for (genvar k = 0; k < mult_ft_pkg::N_REP; k++) begin : g_rep
		assign lane_o[k].enable = sel_lane3_i[k] ? enable_i[SPARE] : enable_i[k];
		assign lane_o[k].op     = sel_lane3_i[k] ? op_i[SPARE] : op_i[k];
		assign lane_o[k].op_a   = sel_lane3_i[k] ? op_a_i[SPARE] : op_a_i[k];
		assign lane_o[k].op_b   = sel_lane3_i[k] ? op_b_i[SPARE] : op_b_i[k];
		assign lane_o[k].op_c   = sel_lane3_i[k] ? op_c_i[SPARE] : op_c_i[k];
	end

endmodule

`default_nettype wire

//--- rtl/mult_unit.sv
// two-stage pipelined integer multiplier replica with MUL, MAC and MULH
`default_nettype none

module mult_unit (
	input wire logic clk,
	input wire logic arst_n_i,

	mult_lane_if.sink lane_i,

	input wire logic ex_ready_i,

	output mult_ft_pkg::data_t result_o,
	output logic valid_o,
	output logic ready_o
);

	localparam int unsigned W = mult_ft_pkg::DATA_W;

	logic stall;
	logic signed [2*W-1:0] prod;

	logic s1_valid_q;
	mult_ft_pkg::mult_op_e s1_op_q;
	logic signed [2*W-1:0] s1_prod_q;
	mult_ft_pkg::data_t s1_c_q;

	logic s2_valid_q;
	mult_ft_pkg::data_t s2_result_d;
	mult_ft_pkg::data_t s2_result_q;

	// hold the whole pipe while the result waits for the EX stage
	assign stall = s2_valid_q & ~ex_ready_i;

	// full signed product, low word is the same for signed and unsigned
	assign prod = $signed(lane_i.op_a) * $signed(lane_i.op_b);

	//////////////////////////////
	// stage 1
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!stall && lane_i.enable) begin
			s1_op_q   <= lane_i.op;
			s1_prod_q <= prod;
			s1_c_q    <= lane_i.op_c;
		end
	end

	//////////////////////////////
	// stage 2
	//////////////////////////////

	always_comb begin
		case (s1_op_q)
			mult_ft_pkg::OP_MAC:  s2_result_d = s1_prod_q[W-1:0] + s1_c_q;
			mult_ft_pkg::OP_MULH: s2_result_d = s1_prod_q[2*W-1:W];
			default:              s2_result_d = s1_prod_q[W-1:0];
		endcase
	end

	// result cleared too, so all replicas start out equal at the voter
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s1_valid_q  <= 1'b0;
			s2_valid_q  <= 1'b0;
			s2_result_q <= '0;
		end else if (!stall) begin
			s1_valid_q <= lane_i.enable;
			s2_valid_q <= s1_valid_q;
			if (s1_valid_q) begin
				s2_result_q <= s2_result_d;
			end
		end
	end

	assign result_o = s2_result_q;
	assign valid_o  = s2_valid_q;
	assign ready_o  = ~stall;

endmodule

`default_nettype wire

//--- rtl/tmr_voter.sv
// majority or pairwise voter over a generic payload with per-input error flags
`default_nettype none

module tmr_voter #(
	parameter type payload_t = logic
) (
	input wire payload_t in_i [3],

	// compare inputs 0 and 1 only, no correction
	input wire logic only_two_i,

	output payload_t voted_o,
	output logic [2:0] err_detected_o,
	output logic err_corrected_o,
	output logic any_err_o
);

	logic eq_01;
	logic eq_02;
	logic eq_12;

	assign eq_01 = (in_i[0] == in_i[1]);
	assign eq_02 = (in_i[0] == in_i[2]);
	assign eq_12 = (in_i[1] == in_i[2]);

	always_comb begin
		voted_o         = in_i[0];
		err_detected_o  = 3'b000;
		err_corrected_o = 1'b0;
		if (only_two_i) begin
			// a mismatch can't be blamed on either side
			err_detected_o[1:0] = {2{~eq_01}};
		end else if (!eq_01 && !eq_02 && !eq_12) begin
			// no majority, input 0 passes through unchecked
			err_detected_o = 3'b111;
		end else if (!eq_01 || !eq_02) begin
			// exactly one input is off, the other two win
			err_corrected_o = 1'b1;
			if (eq_01) begin
				err_detected_o[2] = 1'b1;
			end else if (eq_02) begin
				err_detected_o[1] = 1'b1;
			end else begin
				voted_o           = in_i[1];
				err_detected_o[0] = 1'b1;
			end
		end
	end

	assign any_err_o = |err_detected_o;

endmodule

`default_nettype wire

//--- rtl/err_counter.sv
// per-replica error counters with sticky permanent-fault flags and CSR access
`default_nettype none

module err_counter #(
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input wire logic clk,
	input wire logic arst_n_i,

	// result handed to EX this cycle
	input wire logic transfer_i,
	input wire logic [mult_ft_pkg::N_REP-1:0] rep_err_i,

	input wire logic [mult_ft_pkg::CSR_ADDR_W-1:0] csr_addr_i,
	input wire logic csr_re_i,
	input wire logic csr_we_i,
	input wire mult_ft_pkg::data_t csr_wdata_i,
	output mult_ft_pkg::data_t csr_rdata_o,

	output logic [mult_ft_pkg::N_REP-1:0] permanent_faulty_o
);

	localparam int unsigned N = mult_ft_pkg::N_REP;
	localparam mult_ft_pkg::cnt_t THRESH = mult_ft_pkg::cnt_t'(FAULT_THRESHOLD);

	mult_ft_pkg::cnt_t cnt_q [N];
	logic [N-1:0] fault_q;

	logic [N-1:0] cnt_sel;
	logic [N-1:0] cnt_inc;
	logic [N-1:0] cnt_hit;
	logic [N-1:0] fault_clr;

	for (genvar k = 0; k < N; k++) begin : g_rep
		localparam logic [mult_ft_pkg::CSR_ADDR_W-1:0] CNT_ADDR =
			mult_ft_pkg::CSR_CNT_BASE + mult_ft_pkg::CSR_ADDR_W'(k);

		assign cnt_sel[k] = (csr_addr_i == CNT_ADDR);
		// saturate instead of wrapping
		assign cnt_inc[k] = transfer_i && rep_err_i[k] && (cnt_q[k] != '1);
		assign cnt_hit[k] = cnt_inc[k] && ((cnt_q[k] + 1'b1) >= THRESH);
	end

	// write-one-to-clear on the flag word
	assign fault_clr = (csr_we_i && (csr_addr_i == mult_ft_pkg::CSR_FAULT_ADDR)) ?
		csr_wdata_i[N-1:0] : '0;

	//////////////////////////////
	// counters and flags
	//////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int k = 0; k < N; k++) begin
				cnt_q[k] <= '0;
			end
			fault_q <= '0;
		end else begin
			for (int k = 0; k < N; k++) begin
				if (csr_we_i && cnt_sel[k]) begin
					cnt_q[k] <= csr_wdata_i[mult_ft_pkg::CNT_W-1:0];
				end else if (cnt_inc[k]) begin
					cnt_q[k] <= cnt_q[k] + 1'b1;
				end
			end
			// a new hit wins over a clear in the same cycle
			fault_q <= (fault_q & ~fault_clr) | cnt_hit;
		end
	end

	//////////////////////////////
	// CSR read
	//////////////////////////////

	always_comb begin
		csr_rdata_o = '0;
		if (csr_re_i) begin
			if (csr_addr_i == mult_ft_pkg::CSR_FAULT_ADDR) begin
				csr_rdata_o[N-1:0] = fault_q;
			end
			for (int k = 0; k < N; k++) begin
				if (cnt_sel[k]) begin
					csr_rdata_o[mult_ft_pkg::CNT_W-1:0] = cnt_q[k];
				end
			end
		end
	end

	assign permanent_faulty_o = fault_q;

endmodule

`default_nettype wire

//--- rtl/mult_ft_top.sv
// fault-tolerant multiplier top with steering, three replicas, voters, bypass and counters
`default_nettype none

module mult_ft_top #(
	parameter int unsigned FAULT_THRESHOLD = 4
) (
	input wire logic clk,
	input wire logic arst_n_i,

	input wire logic [mult_ft_pkg::N_LANES-1:0] enable_i,
	input wire mult_ft_pkg::mult_op_e [mult_ft_pkg::N_LANES-1:0] op_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_a_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_b_i,
	input wire mult_ft_pkg::data_t [mult_ft_pkg::N_LANES-1:0] op_c_i,

	input wire logic [mult_ft_pkg::N_REP-1:0] sel_lane3_i,
	input wire logic only_two_i,
	input wire logic [1:0] sel_only_two_i,
	input wire logic [1:0] sel_bypass_i,

	input wire logic ex_ready_i,
	output mult_ft_pkg::data_t result_o,
	output logic result_valid_o,
	output logic ready_o,

	output logic err_detected_o,
	output logic err_corrected_o,
	output logic [mult_ft_pkg::N_REP-1:0] permanent_faulty_o,

	input wire logic [mult_ft_pkg::CSR_ADDR_W-1:0] csr_addr_i,
	input wire logic csr_re_i,
	input wire logic csr_we_i,
	input wire mult_ft_pkg::data_t csr_wdata_i,
	output mult_ft_pkg::data_t csr_rdata_o
);

	mult_lane_if lane_if [mult_ft_pkg::N_REP] ();

	mult_ft_pkg::data_t rep_result [mult_ft_pkg::N_REP];
	logic [mult_ft_pkg::N_REP-1:0] rep_valid;
	logic [mult_ft_pkg::N_REP-1:0] rep_ready;

	mult_ft_pkg::data_t vote_result [3];
	logic vote_valid [3];

	mult_ft_pkg::data_t voted_result;
	logic voted_valid;
	logic [2:0] data_err;
	logic [2:0] valid_err;
	logic data_corr;
	logic valid_corr;
	logic data_any;
	logic valid_any;

	//////////////////////////////
	// replicas
	//////////////////////////////

	lane_steer u_steer (
		.enable_i    (enable_i),
		.op_i        (op_i),
		.op_a_i      (op_a_i),
		.op_b_i      (op_b_i),
		.op_c_i      (op_c_i),
		.sel_lane3_i (sel_lane3_i),
		.lane_o      (lane_if)
	);

	for (genvar k = 0; k < mult_ft_pkg::N_REP; k++) begin : g_rep
		mult_unit u_mult (
			.clk        (clk),
			.arst_n_i   (arst_n_i),
			.lane_i     (lane_if[k]),
			.ex_ready_i (ex_ready_i),
			.result_o   (rep_result[k]),
			.valid_o    (rep_valid[k]),
			.ready_o    (rep_ready[k])
		);
	end

	//////////////////////////////
	// only-two remap and voting
	//////////////////////////////

	// with one replica retired, replica 2 can stand in for voter input 0 or 1
	for (genvar k = 0; k < 2; k++) begin : g_remap
		assign vote_result[k] = sel_only_two_i[k] ? rep_result[2] : rep_result[k];
		assign vote_valid[k]  = sel_only_two_i[k] ? rep_valid[2] : rep_valid[k];
	end
	assign vote_result[2] = rep_result[2];
	assign vote_valid[2]  = rep_valid[2];

	tmr_voter #(
		.payload_t (mult_ft_pkg::data_t)
	) u_vote_data (
		.in_i            (vote_result),
		.only_two_i      (only_two_i),
		.voted_o         (voted_result),
		.err_detected_o  (data_err),
		.err_corrected_o (data_corr),
		.any_err_o       (data_any)
	);

	tmr_voter #(
		.payload_t (logic)
	) u_vote_valid (
		.in_i            (vote_valid),
		.only_two_i      (only_two_i),
		.voted_o         (voted_valid),
		.err_detected_o  (valid_err),
		.err_corrected_o (valid_corr),
		.any_err_o       (valid_any)
	);

	assign err_detected_o  = data_any | valid_any;
	assign err_corrected_o = data_corr | valid_corr;

	// bypass hands one raw replica straight to EX
	always_comb begin
		if (sel_bypass_i == 2'd0) begin
			result_o       = voted_result;
			result_valid_o = voted_valid;
			// replicas share ex_ready, so their stalls line up
			ready_o        = &rep_ready;
		end else begin
			result_o       = rep_result[sel_bypass_i - 2'd1];
			result_valid_o = rep_valid[sel_bypass_i - 2'd1];
			ready_o        = rep_ready[sel_bypass_i - 2'd1];
		end
	end

	err_counter #(
		.FAULT_THRESHOLD (FAULT_THRESHOLD)
	) u_err_cnt (
		.clk                (clk),
		.arst_n_i           (arst_n_i),
		.transfer_i         (result_valid_o & ex_ready_i),
		.rep_err_i          (data_err | valid_err),
		.csr_addr_i         (csr_addr_i),
		.csr_re_i           (csr_re_i),
		.csr_we_i           (csr_we_i),
		.csr_wdata_i        (csr_wdata_i),
		.csr_rdata_o        (csr_rdata_o),
		.permanent_faulty_o (permanent_faulty_o)
	);

endmodule

`default_nettype wire

//--- tb/mult_ft_chk.sv
// concurrent assertions on the multiplier top-level handshake, error flags and reset values
`default_nettype none

module mult_ft_chk (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic [3:0] enable_i,
	input wire logic ready_i,
	input wire logic ex_ready_i,
	input wire mult_ft_pkg::data_t result_i,
	input wire logic result_valid_i,
	input wire logic err_detected_i,
	input wire logic err_corrected_i,
	input wire logic [2:0] permanent_faulty_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// assertion failures so far
	int fail_count = 0;

	// accepted with EX ready, result shows two cycles later
	latency_two: assert property (@(posedge clk) disable iff (!arst_n_i)
		(|enable_i && ready_i && ex_ready_i) |-> ##2 result_valid_i)
		else begin
			$error("result valid missing two cycles after acceptance");
			fail_count++;
		end

	// a stalled result must not move
	hold_on_stall: assert property (@(posedge clk) disable iff (!arst_n_i)
		(result_valid_i && !ex_ready_i) |=> $stable(result_i))
		else begin
			$error("result changed while stalled");
			fail_count++;
		end

	corr_implies_det: assert property (@(posedge clk) disable iff (!arst_n_i)
		err_corrected_i |-> err_detected_i)
		else begin
			$error("corrected error without detected error");
			fail_count++;
		end

	// sampled mid-cycle, after the first reset edge has cleared the registers
	reset_values: assert property (@(negedge clk)
		!arst_n_i |-> (!result_valid_i && !err_detected_i && !err_corrected_i
			&& (permanent_faulty_i == 3'b000) && ready_i))
		else begin
			$error("outputs not at reset values during reset");
			fail_count++;
		end

endmodule

bind mult_ft_top mult_ft_chk u_chk (
	.clk                (clk),
	.arst_n_i           (arst_n_i),
	.enable_i           (enable_i),
	.ready_i            (ready_o),
	.ex_ready_i         (ex_ready_i),
	.result_i           (result_o),
	.result_valid_i     (result_valid_o),
	.err_detected_i     (err_detected_o),
	.err_corrected_i    (err_corrected_o),
	.permanent_faulty_i (permanent_faulty_o)
);

`default_nettype wire

//--- tb/mult_ft_tb.sv
// testbench for the fault-tolerant multiplier: clock, reset, stimulus table, model, checks, report
`default_nettype none

module mult_ft_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned THRESHOLD = 4;
	localparam int N_ROWS = 16;
	localparam int MAX_CYCLES = 40 * N_ROWS + 100;
	// flips bit 31 and bit 0 of op_a on the corrupted lane
	localparam mult_ft_pkg::data_t CORRUPT = 32'h8000_0001;
	localparam logic [2:0] NO_LANE = 3'd4;

	typedef struct packed {
		mult_ft_pkg::mult_op_e op;
		logic [2:0] bad_lane;
		logic [2:0] sel_lane3;
		logic only_two;
		logic [1:0] sel_only_two;
		logic [1:0] sel_bypass;
		logic exp_bad;
		logic exp_det;
		logic exp_corr;
		logic [2:0] exp_cnt_inc;
	} row_t;

	// op, bad lane, sel_lane3, only_two, sel_only_two, bypass, bad result, det, corr, counted
	localparam row_t ROWS [N_ROWS] = '{
		'{mult_ft_pkg::OP_MUL,  NO_LANE, 3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MAC,  NO_LANE, 3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MULH, NO_LANE, 3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MUL,  3'd1,    3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b1, 1'b1, 3'b010},
		'{mult_ft_pkg::OP_MAC,  3'd1,    3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b1, 1'b1, 3'b010},
		'{mult_ft_pkg::OP_MULH, 3'd0,    3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b1, 1'b1, 3'b001},
		'{mult_ft_pkg::OP_MUL,  3'd2,    3'b100, 1'b0, 2'b00, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MAC,  3'd0,    3'b001, 1'b0, 2'b00, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MULH, 3'd1,    3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b1, 1'b1, 3'b010},
		'{mult_ft_pkg::OP_MUL,  3'd1,    3'b000, 1'b0, 2'b00, 2'd0, 1'b0, 1'b1, 1'b1, 3'b010},
		'{mult_ft_pkg::OP_MAC,  3'd1,    3'b000, 1'b1, 2'b00, 2'd0, 1'b0, 1'b1, 1'b0, 3'b011},
		'{mult_ft_pkg::OP_MUL,  3'd2,    3'b000, 1'b1, 2'b01, 2'd0, 1'b1, 1'b1, 1'b0, 3'b011},
		'{mult_ft_pkg::OP_MUL,  3'd1,    3'b000, 1'b1, 2'b10, 2'd0, 1'b0, 1'b0, 1'b0, 3'b000},
		'{mult_ft_pkg::OP_MAC,  3'd1,    3'b000, 1'b0, 2'b00, 2'd2, 1'b1, 1'b1, 1'b1, 3'b010},
		'{mult_ft_pkg::OP_MULH, 3'd0,    3'b000, 1'b0, 2'b00, 2'd1, 1'b1, 1'b1, 1'b1, 3'b001},
		'{mult_ft_pkg::OP_MULH, 3'd2,    3'b000, 1'b0, 2'b00, 2'd3, 1'b1, 1'b1, 1'b1, 3'b100}
	};

	logic clk;
	logic arst_n;
	logic [3:0] enable;
	mult_ft_pkg::mult_op_e [3:0] op;
	mult_ft_pkg::data_t [3:0] op_a;
	mult_ft_pkg::data_t [3:0] op_b;
	mult_ft_pkg::data_t [3:0] op_c;
	logic [2:0] sel_lane3;
	logic only_two;
	logic [1:0] sel_only_two;
	logic [1:0] sel_bypass;
	logic ex_ready;
	mult_ft_pkg::data_t result;
	logic result_valid;
	logic ready;
	logic err_det;
	logic err_corr;
	logic [2:0] perm_fault;
	logic [11:0] csr_addr;
	logic csr_re;
	logic csr_we;
	mult_ft_pkg::data_t csr_wdata;
	mult_ft_pkg::data_t csr_rdata;

	logic [31:0] rng_state;
	int cycles;
	int err_count;
	int test_count;
	int failed_tests;
	int errs_before;
	mult_ft_pkg::cnt_t exp_cnt [3];
	logic [2:0] exp_fault;

	mult_ft_top #(
		.FAULT_THRESHOLD (THRESHOLD)
	) DUT (
		.clk                (clk),
		.arst_n_i           (arst_n),
		.enable_i           (enable),
		.op_i               (op),
		.op_a_i             (op_a),
		.op_b_i             (op_b),
		.op_c_i             (op_c),
		.sel_lane3_i        (sel_lane3),
		.only_two_i         (only_two),
		.sel_only_two_i     (sel_only_two),
		.sel_bypass_i       (sel_bypass),
		.ex_ready_i         (ex_ready),
		.result_o           (result),
		.result_valid_o     (result_valid),
		.ready_o            (ready),
		.err_detected_o     (err_det),
		.err_corrected_o    (err_corr),
		.permanent_faulty_o (perm_fault),
		.csr_addr_i         (csr_addr),
		.csr_re_i           (csr_re),
		.csr_we_i           (csr_we),
		.csr_wdata_i        (csr_wdata),
		.csr_rdata_o        (csr_rdata)
	);

	always #10 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	//////////////////////////////
	// model and helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// low word, low word plus c, or high word of the signed 64-bit product
	function automatic mult_ft_pkg::data_t expected_result(input mult_ft_pkg::mult_op_e o,
			input mult_ft_pkg::data_t a, input mult_ft_pkg::data_t b, input mult_ft_pkg::data_t c);
		longint p;
		p = longint'($signed(a)) * longint'($signed(b));
		case (o)
			mult_ft_pkg::OP_MAC:  return p[31:0] + c;
			mult_ft_pkg::OP_MULH: return p[63:32];
			default:              return p[31:0];
		endcase
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		test_count++;
		if (err_count == errs_at_start) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", test_count, name, err_count - errs_at_start);
		end
	endtask

	// same request on all lanes, op_a altered on bad_lane
	task automatic drive_lanes(input mult_ft_pkg::mult_op_e o, input mult_ft_pkg::data_t a,
			input mult_ft_pkg::data_t b, input mult_ft_pkg::data_t c, input logic [2:0] bad_lane);
		for (int l = 0; l < 4; l++) begin
			enable[l] <= 1'b1;
			op[l]     <= o;
			op_a[l]   <= (l == bad_lane) ? (a ^ CORRUPT) : a;
			op_b[l]   <= b;
			op_c[l]   <= c;
		end
	endtask

	task automatic read_csr(input logic [11:0] addr, output mult_ft_pkg::data_t val);
		@(posedge clk);
		csr_addr <= addr;
		csr_re   <= 1'b1;
		@(negedge clk);
		val = csr_rdata;
	endtask

	task automatic write_csr(input logic [11:0] addr, input mult_ft_pkg::data_t data);
		@(posedge clk);
		csr_addr  <= addr;
		csr_wdata <= data;
		csr_re    <= 1'b0;
		csr_we    <= 1'b1;
		@(posedge clk);
		csr_we <= 1'b0;
	endtask

	task automatic check_counters();
		mult_ft_pkg::data_t rd;
		for (int k = 0; k < 3; k++) begin
			read_csr(mult_ft_pkg::CSR_CNT_BASE + 12'(k), rd);
			check_val($sformatf("csr counter %0d", k), rd, exp_cnt[k]);
		end
		check_val("permanent_faulty_o", perm_fault, exp_fault);
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic run_row(input row_t r);
		mult_ft_pkg::data_t a;
		mult_ft_pkg::data_t b;
		mult_ft_pkg::data_t c;
		mult_ft_pkg::data_t a_exp;
		int waited;
		rng_state = xorshift(rng_state);
		a = rng_state;
		rng_state = xorshift(rng_state);
		// odd b keeps a corrupted low word distinct
		b = rng_state | 32'h1;
		rng_state = xorshift(rng_state);
		c = rng_state;
		a_exp = r.exp_bad ? (a ^ CORRUPT) : a;
		@(posedge clk);
		sel_lane3    <= r.sel_lane3;
		only_two     <= r.only_two;
		sel_only_two <= r.sel_only_two;
		sel_bypass   <= r.sel_bypass;
		csr_re       <= 1'b0;
		drive_lanes(r.op, a, b, c, r.bad_lane);
		@(posedge clk);
		enable <= '0;
		waited = 0;
		@(negedge clk);
		while (!result_valid) begin
			waited++;
			@(negedge clk);
		end
		assert (waited == 1) else begin
			$display("result valid came %0d cycles after acceptance instead of 2", waited + 1);
			err_count++;
		end
		check_val("result_o", result, expected_result(r.op, a_exp, b, c));
		check_val("err_detected_o", err_det, r.exp_det);
		check_val("err_corrected_o", err_corr, r.exp_corr);
		// transfer on the coming edge, ex_ready is high
		for (int k = 0; k < 3; k++) begin
			if (r.exp_cnt_inc[k]) begin
				exp_cnt[k]++;
				if (exp_cnt[k] >= THRESHOLD) begin
					exp_fault[k] = 1'b1;
				end
			end
		end
		check_counters();
	endtask

	task automatic stall_test();
		mult_ft_pkg::data_t a1;
		mult_ft_pkg::data_t a2;
		mult_ft_pkg::data_t b;
		mult_ft_pkg::data_t c;
		rng_state = xorshift(rng_state);
		a1 = rng_state;
		rng_state = xorshift(rng_state);
		a2 = rng_state;
		rng_state = xorshift(rng_state);
		b = rng_state;
		rng_state = xorshift(rng_state);
		c = rng_state;
		@(posedge clk);
		sel_lane3    <= '0;
		only_two     <= 1'b0;
		sel_only_two <= '0;
		sel_bypass   <= '0;
		csr_re       <= 1'b0;
		ex_ready     <= 1'b0;
		drive_lanes(mult_ft_pkg::OP_MUL, a1, b, c, NO_LANE);
		@(posedge clk);
		drive_lanes(mult_ft_pkg::OP_MAC, a2, b, c, NO_LANE);
		@(posedge clk);
		enable <= '0;
		// both ops in flight, first one parked in stage 2
		repeat (3) begin
			@(negedge clk);
			check_val("result_valid_o", result_valid, 1'b1);
			check_val("ready_o", ready, 1'b0);
			check_val("result_o", result, expected_result(mult_ft_pkg::OP_MUL, a1, b, c));
		end
		@(posedge clk);
		ex_ready <= 1'b1;
		@(negedge clk);
		check_val("result_valid_o", result_valid, 1'b1);
		check_val("result_o", result, expected_result(mult_ft_pkg::OP_MUL, a1, b, c));
		@(negedge clk);
		check_val("result_valid_o", result_valid, 1'b1);
		check_val("result_o", result, expected_result(mult_ft_pkg::OP_MAC, a2, b, c));
		@(negedge clk);
		check_val("result_valid_o", result_valid, 1'b0);
	endtask

	initial begin
		mult_ft_pkg::data_t rd;
		clk          = 1'b0;
		arst_n       = 1'b0;
		enable       = '0;
		op_a         = '0;
		op_b         = '0;
		op_c         = '0;
		sel_lane3    = '0;
		only_two     = 1'b0;
		sel_only_two = '0;
		sel_bypass   = '0;
		ex_ready     = 1'b1;
		csr_addr     = '0;
		csr_re       = 1'b0;
		csr_we       = 1'b0;
		csr_wdata    = '0;
		for (int l = 0; l < 4; l++) begin
			op[l] = mult_ft_pkg::OP_MUL;
		end
		rng_state    = 32'd77025;
		cycles       = 0;
		err_count    = 0;
		test_count   = 0;
		failed_tests = 0;
		exp_fault    = '0;
		for (int k = 0; k < 3; k++) begin
			exp_cnt[k] = '0;
		end

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < N_ROWS; i++) begin
			errs_before = err_count;
			run_row(ROWS[i]);
			finish_test($sformatf("table row %0d", i), errs_before);
		end

		// replicas 0 and 1 crossed the threshold in the table, only flag 1 is cleared
		errs_before = err_count;
		check_val("permanent_faulty_o", perm_fault, 3'b011);
		write_csr(mult_ft_pkg::CSR_FAULT_ADDR, 32'h0000_0002);
		exp_fault[1] = 1'b0;
		read_csr(mult_ft_pkg::CSR_FAULT_ADDR, rd);
		check_val("csr fault word", rd, 32'h0000_0001);
		check_val("permanent_faulty_o", perm_fault, exp_fault);
		finish_test("fault flag clear", errs_before);

		errs_before = err_count;
		write_csr(mult_ft_pkg::CSR_CNT_BASE + 12'd2, 32'hABCD_1234);
		exp_cnt[2] = 16'h1234;
		check_counters();
		finish_test("counter load", errs_before);

		errs_before = err_count;
		stall_test();
		check_counters();
		finish_test("stall and release", errs_before);

		if (DUT.u_chk.fail_count != 0) begin
			$display("bound assertions on the DUT failed %0d times", DUT.u_chk.fail_count);
			err_count += DUT.u_chk.fail_count;
		end

		$display("tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, err_count);
		if (err_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mult_ft_pkg.sv
rtl/mult_lane_if.sv
rtl/lane_steer.sv
rtl/mult_unit.sv
rtl/tmr_voter.sv
rtl/err_counter.sv
rtl/mult_ft_top.sv
tb/mult_ft_chk.sv
tb/mult_ft_tb.sv

//--- Bender.yml
package:
  name: mult_ft

sources:
  # package and interface first
  - rtl/mult_ft_pkg.sv
  - rtl/mult_lane_if.sv
  - rtl/lane_steer.sv
  - rtl/mult_unit.sv
  - rtl/tmr_voter.sv
  - rtl/err_counter.sv
  - rtl/mult_ft_top.sv
  - target: test
    files:
      - tb/mult_ft_chk.sv
      - tb/mult_ft_tb.sv
